/* hdl/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // data path
    localparam int WORD_BITS   = 32;
    localparam int STROBE_BITS = 4;

    // geometry, 16 KB over 2 ways
    localparam int WORDS_PER_LINE = 16;
    localparam int WAYS           = 2;
    localparam int SETS           = 128;

    // address split
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 7;
    localparam int ALIGN_BITS  = 2;
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [WORD_BITS-1:0]   word_t;
    typedef logic [STROBE_BITS-1:0] strobe_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [$clog2(WAYS)-1:0] way_t;

    // byte address as seen on both buses
    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } addr_t;

    // word address into the data array
    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } ram_addr_t;

    // refill sequencing
    typedef enum logic [1:0] {
        IDLE,
        WB_READ,
        WB_SEND,
        FETCH
    } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/ram_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if;

    logic                  en;
    dcache_pkg::strobe_t   strobe;
    dcache_pkg::ram_addr_t addr;
    dcache_pkg::word_t     wdata;
    dcache_pkg::word_t     rdata;

    modport ctrl (
        output en,
        output strobe,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  en,
        input  strobe,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* hdl/tag_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface tag_if;

    // lookup and update requests
    dcache_pkg::index_t look_index;
    dcache_pkg::tag_t   look_tag;
    logic               hit_touch;
    logic               hit_write;
    logic               fill_en;

    // lookup results
    logic               hit;
    dcache_pkg::way_t   hit_way;
    dcache_pkg::way_t   victim_way;
    logic               victim_valid;
    logic               victim_dirty;
    dcache_pkg::tag_t   victim_tag;

    modport ctrl (
        output look_index, look_tag, hit_touch, hit_write, fill_en,
        input  hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
    );

    modport store (
        input  look_index, look_tag, hit_touch, hit_write, fill_en,
        output hit, hit_way, victim_way, victim_valid, victim_dirty, victim_tag
    );

endinterface

`default_nettype wire

/* hdl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
    input logic     clk,
    ram_port_if.ram a_port,
    ram_port_if.ram b_port
);

    localparam int DEPTH = dcache_pkg::WAYS * dcache_pkg::SETS * dcache_pkg::WORDS_PER_LINE;

    dcache_pkg::word_t mem [DEPTH];

    // both ports in one process; port b wins a same-word write collision
    always_ff @(posedge clk) begin
        if (a_port.en) begin
            // old contents come back on a write too
            a_port.rdata <= mem[a_port.addr];
            for (int b = 0; b < dcache_pkg::STROBE_BITS; b++) begin
                if (a_port.strobe[b]) begin
                    mem[a_port.addr][b*8 +: 8] <= a_port.wdata[b*8 +: 8];
                end
            end
        end
        if (b_port.en) begin
            b_port.rdata <= mem[b_port.addr];
            for (int b = 0; b < dcache_pkg::STROBE_BITS; b++) begin
                if (b_port.strobe[b]) begin
                    mem[b_port.addr][b*8 +: 8] <= b_port.wdata[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_store (
    input logic   clk,
    input logic   resetn,
    tag_if.store  tags
);

    localparam int WAYS = dcache_pkg::WAYS;
    localparam int SETS = dcache_pkg::SETS;

    // per-line state
    dcache_pkg::tag_t            tag_mem [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0]   valid_bits;
    logic [WAYS-1:0][SETS-1:0]   dirty_bits;
    // one plru bit per set, names the next victim
    logic [SETS-1:0]             plru_bits;

    logic [WAYS-1:0]             way_hit;
    dcache_pkg::way_t            victim;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_bits[w][tags.look_index]
                && (tag_mem[w][tags.look_index] == tags.look_tag);
        end
    end

    assign tags.hit = |way_hit;

    always_comb begin
        tags.hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_hit[w]) begin
                tags.hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign victim            = plru_bits[tags.look_index];
    assign tags.victim_way   = victim;
    assign tags.victim_valid = valid_bits[victim][tags.look_index];
    assign tags.victim_dirty = dirty_bits[victim][tags.look_index];
    assign tags.victim_tag   = tag_mem[victim][tags.look_index];

    // tag payload, written on refill only
    always_ff @(posedge clk) begin
        if (tags.fill_en) begin
            tag_mem[victim][tags.look_index] <= tags.look_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            plru_bits  <= '0;
        end else begin
            if (tags.hit_touch) begin
                plru_bits[tags.look_index] <= ~tags.hit_way;
                if (tags.hit_write) begin
                    dirty_bits[tags.hit_way][tags.look_index] <= 1'b1;
                end
            end
            // refill lands in the victim way, clean
            if (tags.fill_en) begin
                valid_bits[victim][tags.look_index] <= 1'b1;
                dirty_bits[victim][tags.look_index] <= 1'b0;
                plru_bits[tags.look_index]          <= ~victim;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                clk,
    input  logic                resetn,

    input  logic                req_valid,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::strobe_t req_strobe,
    input  dcache_pkg::word_t   req_data,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   resp_data,

    output logic                creq_valid,
    output logic                creq_is_write,
    output dcache_pkg::addr_t   creq_addr,
    output dcache_pkg::word_t   creq_data,
    input  logic                cresp_ready,
    input  logic                cresp_last,
    input  dcache_pkg::word_t   cresp_data,

    tag_if.ctrl                 tags,
    ram_port_if.ctrl            req_port,
    ram_port_if.ctrl            line_port
);

    localparam int OFFSET_BITS = dcache_pkg::OFFSET_BITS;

    dcache_pkg::ctrl_state_t state;
    // wide enough for the extra latency cycle of WB_READ
    logic [OFFSET_BITS:0]    beat;
    dcache_pkg::offset_t     beat_off;
    dcache_pkg::word_t       line_buf [dcache_pkg::WORDS_PER_LINE];
    logic                    accept;
    logic                    miss;

    assign beat_off = beat[OFFSET_BITS-1:0];

    assign tags.look_index = req_addr.index;
    assign tags.look_tag   = req_addr.tag;

    assign accept = (state == dcache_pkg::IDLE) && req_valid && tags.hit;
    assign miss   = (state == dcache_pkg::IDLE) && req_valid && !tags.hit;

    assign addr_ok        = accept;
    assign tags.hit_touch = accept;
    assign tags.hit_write = accept && (|req_strobe);
    assign tags.fill_en   = (state == dcache_pkg::FETCH) && cresp_ready && cresp_last;

    // hit path
    assign req_port.en     = accept;
    assign req_port.strobe = req_strobe;
    assign req_port.addr   = {tags.hit_way, req_addr.index, req_addr.offset};
    assign req_port.wdata  = req_data;
    assign resp_data       = req_port.rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= accept;
        end
    end

    // refill path, victim way stays put until fill_en
    always_comb begin
        line_port.addr   = {tags.victim_way, req_addr.index, beat_off};
        line_port.wdata  = cresp_data;
        line_port.en     = 1'b0;
        line_port.strobe = '0;
        case (state)
            dcache_pkg::WB_READ: begin
                line_port.en = !beat[OFFSET_BITS];
            end
            dcache_pkg::FETCH: begin
                line_port.en     = cresp_ready;
                line_port.strobe = '1;
            end
            default: begin
            end
        endcase
    end

    // words land one cycle after their read
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::WB_READ && beat != '0) begin
            line_buf[dcache_pkg::offset_t'(beat - 1'b1)] <= line_port.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= dcache_pkg::IDLE;
            beat  <= '0;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    beat <= '0;
                    if (miss) begin
                        if (tags.victim_valid && tags.victim_dirty) begin
                            state <= dcache_pkg::WB_READ;
                        end else begin
                            state <= dcache_pkg::FETCH;
                        end
                    end
                end
                dcache_pkg::WB_READ: begin
                    if (beat[OFFSET_BITS]) begin
                        state <= dcache_pkg::WB_SEND;
                        beat  <= '0;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
                dcache_pkg::WB_SEND: begin
                    if (cresp_ready) begin
                        beat <= beat + 1'b1;
                        if (cresp_last) begin
                            state <= dcache_pkg::FETCH;
                            beat  <= '0;
                        end
                    end
                end
                dcache_pkg::FETCH: begin
                    if (cresp_ready) begin
                        beat <= beat + 1'b1;
                        if (cresp_last) begin
                            state <= dcache_pkg::IDLE;
                            beat  <= '0;
                        end
                    end
                end
                default: begin
                    state <= dcache_pkg::IDLE;
                end
            endcase
        end
    end

    // memory bus, line-aligned bursts from word 0
    assign creq_valid    = (state == dcache_pkg::WB_SEND) || (state == dcache_pkg::FETCH);
    assign creq_is_write = (state == dcache_pkg::WB_SEND);
    assign creq_data     = line_buf[beat_off];

    always_comb begin
        creq_addr        = '0;
        creq_addr.index  = req_addr.index;
        creq_addr.tag    = req_addr.tag;
        if (state == dcache_pkg::WB_SEND) begin
            creq_addr.tag = tags.victim_tag;
        end
    end

endmodule

`default_nettype wire

/* hdl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                clk,
    input  logic                resetn,

    // request port
    input  logic                req_valid,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::strobe_t req_strobe,
    input  dcache_pkg::word_t   req_data,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   resp_data,

    // memory bus
    output logic                creq_valid,
    output logic                creq_is_write,
    output dcache_pkg::addr_t   creq_addr,
    output dcache_pkg::word_t   creq_data,
    input  logic                cresp_ready,
    input  logic                cresp_last,
    input  dcache_pkg::word_t   cresp_data
);

    tag_if      tags ();
    ram_port_if req_port ();
    ram_port_if line_port ();

    tag_store u_tag_store (
        .clk    (clk),
        .resetn (resetn),
        .tags   (tags.store)
    );

    cache_ctrl u_cache_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_strobe    (req_strobe),
        .req_data      (req_data),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .resp_data     (resp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data),
        .tags          (tags.ctrl),
        .req_port      (req_port.ctrl),
        .line_port     (line_port.ctrl)
    );

    // port a serves hits, port b serves refill and writeback
    data_ram u_data_ram (
        .clk    (clk),
        .a_port (req_port.ram),
        .b_port (line_port.ram)
    );

endmodule

`default_nettype wire

/* tests/dcache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_checker (
    input logic              clk,
    input logic              resetn,
    input logic              addr_ok,
    input logic              data_ok,
    input logic              creq_valid,
    input logic              creq_is_write,
    input dcache_pkg::addr_t creq_addr
);

    int failures = 0;

    // hit data returns exactly one cycle after acceptance
    a_data_after_addr: assert property (@(posedge clk) disable iff (resetn)
        addr_ok |=> data_ok)
        else begin
            $error("data_ok missing one cycle after addr_ok");
            failures++;
        end

    a_data_needs_addr: assert property (@(posedge clk) disable iff (resetn)
        data_ok |-> $past(addr_ok))
        else begin
            $error("data_ok without addr_ok in the previous cycle");
            failures++;
        end

    // each burst holds its own address
    a_creq_addr_stable: assert property (@(posedge clk) disable iff (resetn)
        (creq_valid && $past(creq_valid) && (creq_is_write == $past(creq_is_write)))
            |-> $stable(creq_addr))
        else begin
            $error("creq_addr changed during a burst");
            failures++;
        end

    a_no_accept_in_burst: assert property (@(posedge clk) disable iff (resetn)
        !(addr_ok && creq_valid))
        else begin
            $error("addr_ok raised while a burst is active");
            failures++;
        end

endmodule

`default_nettype wire

/* tests/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int TIMEOUT    = 2000;
    localparam int HIT        = 0;
    localparam int CLEAN_MISS = 1;
    localparam int DIRTY_MISS = 2;
    localparam int N_REQ      = 16;

    typedef struct {
        logic [31:0] addr;
        logic [3:0]  strobe;
        logic [31:0] data;
        int          kind;
    } req_entry_t;

    // set 5 holds line a (tag 0), b (tag 1) and c (tag 2)
    req_entry_t req_table [N_REQ] = '{
        '{32'h0000_0140, 4'h0, 32'h0000_0000, CLEAN_MISS},
        '{32'h0000_0144, 4'h0, 32'h0000_0000, HIT},
        '{32'h0000_0148, 4'h6, 32'hdead_beef, HIT},
        '{32'h0000_0148, 4'h0, 32'h0000_0000, HIT},
        '{32'h0000_014c, 4'hf, 32'h0123_4567, HIT},
        '{32'h0000_2140, 4'h0, 32'h0000_0000, CLEAN_MISS},
        '{32'h0000_0144, 4'h0, 32'h0000_0000, HIT},
        '{32'h0000_4140, 4'h0, 32'h0000_0000, CLEAN_MISS},
        '{32'h0000_0148, 4'h0, 32'h0000_0000, HIT},
        '{32'h0000_2150, 4'h0, 32'h0000_0000, CLEAN_MISS},
        '{32'h0000_4144, 4'h0, 32'h0000_0000, DIRTY_MISS},
        '{32'h0000_0148, 4'h0, 32'h0000_0000, CLEAN_MISS},
        '{32'h0000_014c, 4'h0, 32'h0000_0000, HIT},
        '{32'h0000_0240, 4'h1, 32'h0000_00a5, CLEAN_MISS},
        '{32'h0000_0240, 4'h0, 32'h0000_0000, HIT},
        '{32'h8000_0280, 4'h0, 32'h0000_0000, CLEAN_MISS}
    };

    logic clk;
    logic resetn;
    logic req_valid;
    logic addr_ok;
    logic data_ok;
    logic creq_valid;
    logic creq_is_write;
    logic cresp_ready;
    logic cresp_last;
    dcache_pkg::addr_t   req_addr;
    dcache_pkg::addr_t   creq_addr;
    dcache_pkg::strobe_t req_strobe;
    dcache_pkg::word_t   req_data;
    dcache_pkg::word_t   resp_data;
    dcache_pkg::word_t   creq_data;
    dcache_pkg::word_t   cresp_data;

    dcache_pkg::word_t shadow [int unsigned];
    dcache_pkg::word_t ref_mem [int unsigned];
    dcache_pkg::word_t exp_q [$];
    logic [31:0] lcg_state = 32'h3ffada4e;
    logic [31:0] last_read_base = '0;
    logic        stall_en = 1'b0;
    logic        in_burst = 1'b0;
    int          beat = 0;
    int          read_bursts = 0;
    int          write_bursts = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    dcache_top UUT (.*);

    bind dcache_top dcache_checker u_checker (
        .clk(clk), .resetn(resetn), .addr_ok(addr_ok), .data_ok(data_ok),
        .creq_valid(creq_valid), .creq_is_write(creq_is_write), .creq_addr(creq_addr)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic dcache_pkg::word_t memory_word(input int unsigned widx);
        if (shadow.exists(widx)) begin
            return shadow[widx];
        end
        return widx ^ 32'h5a5a0000;
    endfunction

    function automatic dcache_pkg::word_t expected_word(input int unsigned widx);
        if (ref_mem.exists(widx)) begin
            return ref_mem[widx];
        end
        return widx ^ 32'h5a5a0000;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory model answering one beat per ready cycle
    initial begin
        logic [31:0] base;
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_data  = '0;
        forever begin
            @(negedge clk);
            lcg_state   = lcg_next(lcg_state);
            cresp_ready = 1'b0;
            cresp_last  = 1'b0;
            base        = creq_addr;
            if (creq_valid && !in_burst) begin
                in_burst = 1'b1;
                beat     = 0;
                if (creq_is_write) begin
                    write_bursts++;
                end else begin
                    read_bursts++;
                    last_read_base = base;
                end
            end
            if (creq_valid && !(stall_en && lcg_state[7])) begin
                cresp_ready = 1'b1;
                cresp_last  = (beat == 15);
                if (creq_is_write) begin
                    shadow[base[31:2] + beat] = creq_data;
                end else begin
                    cresp_data = memory_word(base[31:2] + beat);
                end
                beat++;
                in_burst = (beat != 16);
            end
        end
    end

    always @(posedge clk) begin : response_monitor
        dcache_pkg::word_t expected;
        if (data_ok) begin
            assert (exp_q.size() > 0) else begin
                $display("data_ok at %0t with no accepted request", $time);
                protocol_errors++;
            end
            if (exp_q.size() > 0) begin
                expected = exp_q.pop_front();
                assert (resp_data === expected) else begin
                    $display("error at %0t: resp_data got %h expected %h",
                        $time, resp_data, expected);
                    value_errors++;
                end
            end
        end
    end

    task automatic apply_reset(input logic stalls);
        @(negedge clk);
        resetn   = 1'b1;
        stall_en = stalls;
        shadow.delete();
        ref_mem.delete();
        exp_q.delete();
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
    endtask

    task automatic check_accept(input int i, input int cycles, input int rd0, input int wr0);
        req_entry_t  e;
        int unsigned widx;
        logic [31:0] line_base;
        e         = req_table[i];
        widx      = e.addr[31:2];
        line_base = {e.addr[31:6], 6'b0};
        exp_q.push_back(expected_word(widx));
        // bytes merged by strobe
        for (int b = 0; b < dcache_pkg::STROBE_BITS; b++) begin
            if (e.strobe[b]) begin
                ref_mem[widx] = expected_word(widx);
                ref_mem[widx][b*8 +: 8] = e.data[b*8 +: 8];
            end
        end
        assert (read_bursts - rd0 == ((e.kind == HIT) ? 0 : 1)) else begin
            $display("request %0d saw %0d read bursts", i, read_bursts - rd0);
            protocol_errors++;
        end
        assert (write_bursts - wr0 == ((e.kind == DIRTY_MISS) ? 1 : 0)) else begin
            $display("request %0d saw %0d write bursts", i, write_bursts - wr0);
            protocol_errors++;
        end
        assert (e.kind == HIT || last_read_base === line_base) else begin
            $display("error at %0t: creq_addr got %h expected %h",
                $time, last_read_base, line_base);
            value_errors++;
        end
        assert (e.kind != HIT || cycles == 1) else begin
            $display("hit request %0d waited %0d cycles for addr_ok", i, cycles);
            protocol_errors++;
        end
    endtask

    initial begin
        int   cycles;
        int   rd0;
        int   wr0;
        int   assert_fails;
        logic hung;
        hung       = 1'b0;
        resetn     = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_strobe = '0;
        req_data   = '0;
        // second pass repeats the table under memory stalls
        for (int pass = 0; pass < 2 && !hung; pass++) begin
            apply_reset(pass == 1);
            repeat (4) begin
                @(posedge clk);
                assert (!addr_ok && !data_ok && !creq_valid) else begin
                    $display("cache outputs active while idle at %0t", $time);
                    protocol_errors++;
                end
            end
            for (int i = 0; i < N_REQ && !hung; i++) begin
                @(negedge clk);
                req_valid  = 1'b1;
                req_addr   = req_table[i].addr;
                req_strobe = req_table[i].strobe;
                req_data   = req_table[i].data;
                rd0        = read_bursts;
                wr0        = write_bursts;
                cycles     = 0;
                do begin
                    @(posedge clk);
                    cycles++;
                end while (!addr_ok && cycles < TIMEOUT);
                if (!addr_ok) begin
                    $display("timeout: request %0d in pass %0d never accepted", i, pass);
                    protocol_errors++;
                    hung = 1'b1;
                end else begin
                    check_accept(i, cycles, rd0, wr0);
                end
            end
            @(negedge clk);
            req_valid = 1'b0;
            cycles    = 0;
            while (exp_q.size() != 0 && cycles < TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (exp_q.size() != 0) begin
                $display("timeout: responses still missing after the last request");
                protocol_errors++;
                hung = 1'b1;
            end
        end
        assert_fails = UUT.u_checker.failures;
        $display("value errors: %0d, protocol errors: %0d, assertion failures: %0d",
            value_errors, protocol_errors, assert_fails);
        if (value_errors + protocol_errors + assert_fails != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hdl/dcache_pkg.sv
hdl/ram_port_if.sv
hdl/tag_if.sv
hdl/data_ram.sv
hdl/tag_store.sv
hdl/cache_ctrl.sv
hdl/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv
